//--- src/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Reset value of the program counter
`define BOOT_ADDRESS 32'h0000_0000

// Number of fetch queue entries as a power of two of at least 2
`define FETCH_QUEUE_DEPTH 4

`endif

//--- src/isa_pkg.sv
package isa_pkg;

    // RV32I base opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // Word width for LW and SW
    localparam logic [2:0] F3_WORD    = 3'b010;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic        sub;
        logic [31:0] imm;
    } decoded_instr_t;

endpackage

//--- src/bus_pkg.sv
package bus_pkg;

    // One fetched instruction and where it came from
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_entry_t;

    // Data bus request with exclusive read and write strobes
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } data_req_t;

endpackage

//--- src/fetch_unit.sv
`include "core_params.svh"

module fetch_unit import bus_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,

    input  logic         redirect_i,
    input  logic [31:0]  redirect_pc_i,

    input  logic         queue_full_i,
    output logic         push_o,
    output fetch_entry_t entry_o,

    output logic         instr_req_o,
    output logic [31:0]  instr_addr_o,
    input  logic         instr_rsp_i,
    input  logic [31:0]  instr_data_i,

    output logic         instr_flush_o
);

    logic [31:0] pc_q;
    logic        req_q;
    logic        rsp_accept;

    // A response in the redirect cycle belongs to the wrong path
    assign rsp_accept = req_q & instr_rsp_i & ~redirect_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q  <= `BOOT_ADDRESS;
            req_q <= 1'b0;
        end else if (redirect_i) begin
            pc_q  <= redirect_pc_i;
            req_q <= 1'b0;
        end else if (req_q) begin
            if (instr_rsp_i) begin
                pc_q  <= pc_q + 32'd4;
                req_q <= 1'b0;
            end
        end else if (!queue_full_i) begin
            // Only request when the answer is sure to find a free slot
            req_q <= 1'b1;
        end
    end

    assign instr_req_o   = req_q;
    assign instr_addr_o  = pc_q;
    assign instr_flush_o = redirect_i;

    assign push_o        = rsp_accept;
    assign entry_o.pc    = pc_q;
    assign entry_o.instr = instr_data_i;

endmodule

//--- src/fetch_queue.sv
`include "core_params.svh"

module fetch_queue import bus_pkg::*; #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic         clk,
    input  logic         reset_i,

    input  logic         push_i,
    input  fetch_entry_t entry_i,
    output logic         full_o,

    input  logic         pop_i,
    output logic         valid_o,
    output fetch_entry_t head_o,

    input  logic         flush_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    fetch_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == FULL_COUNT);
    assign valid_o = (count_q != '0);
    assign head_o  = mem[rd_ptr_q];

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & valid_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- src/register_bank.sv
module register_bank (
    input  logic        clk,

    input  logic        wr_en_i,
    input  logic [4:0]  rd_addr_i,
    input  logic [31:0] rd_data_i,

    input  logic [4:0]  rs1_addr_i,
    input  logic [4:0]  rs2_addr_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en_i && (rd_addr_i != 5'd0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 : regs[rs2_addr_i];

endmodule

//--- src/execute_unit.sv
module execute_unit import isa_pkg::*, bus_pkg::*; (
    input  logic         clk,
    input  logic         reset_i,

    input  logic         valid_i,
    input  fetch_entry_t entry_i,
    output logic         pop_o,

    output logic [4:0]   rs1_addr_o,
    output logic [4:0]   rs2_addr_o,
    input  logic [31:0]  rs1_data_i,
    input  logic [31:0]  rs2_data_i,

    output logic         wr_en_o,
    output logic [4:0]   rd_addr_o,
    output logic [31:0]  rd_data_o,

    output logic         redirect_o,
    output logic [31:0]  redirect_pc_o,

    output data_req_t    data_req_o,
    input  logic         data_rsp_i,
    input  logic [31:0]  data_read_i
);

    decoded_instr_t dec;
    logic [31:0]    ir;
    logic           is_lui;
    logic           is_op_imm;
    logic           is_op;
    logic           is_load;
    logic           is_store;
    logic           is_branch;
    logic           is_jal;
    logic           is_mem;
    logic           mem_busy_q;
    logic           mem_done;
    logic           branch_taken;
    logic [31:0]    alu_b;
    logic [31:0]    alu_result;
    logic [31:0]    mem_addr;

    assign ir = entry_i.instr;

    always_comb begin
        dec.opcode = ir[6:0];
        dec.rd     = ir[11:7];
        dec.funct3 = ir[14:12];
        dec.rs1    = ir[19:15];
        dec.rs2    = ir[24:20];
        dec.sub    = ir[30];
        case (ir[6:0])
            OPC_LUI:    dec.imm = {ir[31:12], 12'b0};
            OPC_STORE:  dec.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH: dec.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_JAL:    dec.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:    dec.imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    assign is_lui    = (dec.opcode == OPC_LUI);
    assign is_op_imm = (dec.opcode == OPC_OP_IMM);
    assign is_op     = (dec.opcode == OPC_OP);
    assign is_branch = (dec.opcode == OPC_BRANCH);
    assign is_jal    = (dec.opcode == OPC_JAL);
    // Only word accesses
    assign is_load   = (dec.opcode == OPC_LOAD) && (dec.funct3 == F3_WORD);
    assign is_store  = (dec.opcode == OPC_STORE) && (dec.funct3 == F3_WORD);
    assign is_mem    = is_load | is_store;

    assign rs1_addr_o = dec.rs1;
    assign rs2_addr_o = dec.rs2;

    // Second ALU operand is rs2 only for register-register ops
    assign alu_b = is_op ? rs2_data_i : dec.imm;

    always_comb begin
        case (dec.funct3)
            F3_ADD_SUB: begin
                if (is_op && dec.sub) begin
                    alu_result = rs1_data_i - alu_b;
                end else begin
                    alu_result = rs1_data_i + alu_b;
                end
            end
            F3_SLT:  alu_result = {31'd0, $signed(rs1_data_i) < $signed(alu_b)};
            F3_XOR:  alu_result = rs1_data_i ^ alu_b;
            F3_OR:   alu_result = rs1_data_i | alu_b;
            F3_AND:  alu_result = rs1_data_i & alu_b;
            default: alu_result = 32'd0;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            F3_BEQ:  branch_taken = (rs1_data_i == rs2_data_i);
            F3_BNE:  branch_taken = (rs1_data_i != rs2_data_i);
            default: branch_taken = 1'b0;
        endcase
    end

    assign redirect_o    = valid_i & (is_jal | (is_branch & branch_taken));
    assign redirect_pc_o = entry_i.pc + dec.imm;

    // Strobe is registered so it drops for a cycle between accesses
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_busy_q <= 1'b0;
        end else if (mem_done) begin
            mem_busy_q <= 1'b0;
        end else if (valid_i && is_mem) begin
            mem_busy_q <= 1'b1;
        end
    end

    assign mem_done = mem_busy_q & data_rsp_i;
    assign mem_addr = rs1_data_i + dec.imm;

    assign data_req_o.read  = mem_busy_q & is_load;
    assign data_req_o.write = mem_busy_q & is_store;
    assign data_req_o.addr  = mem_addr;
    assign data_req_o.wdata = rs2_data_i;

    // Anything else retires in its first cycle at the head
    assign pop_o = valid_i & (is_mem ? mem_done : 1'b1);

    assign wr_en_o   = valid_i & ((is_lui | is_op_imm | is_op | is_jal) | (is_load & mem_done));
    assign rd_addr_o = dec.rd;

    always_comb begin
        if (is_lui) begin
            rd_data_o = dec.imm;
        end else if (is_jal) begin
            rd_data_o = entry_i.pc + 32'd4;
        end else if (is_load) begin
            rd_data_o = data_read_i;
        end else begin
            rd_data_o = alu_result;
        end
    end

endmodule

//--- src/core.sv
`include "core_params.svh"

module core import bus_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,

    // Instruction bus
    output logic        instr_flush_o,
    output logic        instr_req_o,
    input  logic        instr_rsp_i,
    input  logic [31:0] instr_data_i,
    output logic [31:0] instr_addr_o,

    // Data bus
    input  logic        data_mem_rsp_i,
    output logic        data_mem_rd_o,
    output logic        data_mem_wr_o,
    input  logic [31:0] data_read_i,
    output logic [31:0] data_addr_o,
    output logic [31:0] data_write_o
);

    logic         push;
    fetch_entry_t fetch_entry;
    logic         queue_full;
    logic         head_valid;
    fetch_entry_t head;
    logic         pop;
    logic         redirect;
    logic [31:0]  redirect_pc;
    logic [4:0]   rs1_addr;
    logic [4:0]   rs2_addr;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    logic         wr_en;
    logic [4:0]   rd_addr;
    logic [31:0]  rd_data;
    data_req_t    data_req;

    fetch_unit u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .queue_full_i  (queue_full),
        .push_o        (push),
        .entry_o       (fetch_entry),
        .instr_req_o   (instr_req_o),
        .instr_addr_o  (instr_addr_o),
        .instr_rsp_i   (instr_rsp_i),
        .instr_data_i  (instr_data_i),
        .instr_flush_o (instr_flush_o)
    );

    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) u_queue (
        .clk     (clk),
        .reset_i (reset_i),
        .push_i  (push),
        .entry_i (fetch_entry),
        .full_o  (queue_full),
        .pop_i   (pop),
        .valid_o (head_valid),
        .head_o  (head),
        .flush_i (redirect)
    );

    execute_unit u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (head_valid),
        .entry_i       (head),
        .pop_o         (pop),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .wr_en_o       (wr_en),
        .rd_addr_o     (rd_addr),
        .rd_data_o     (rd_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .data_req_o    (data_req),
        .data_rsp_i    (data_mem_rsp_i),
        .data_read_i   (data_read_i)
    );

    register_bank u_regs (
        .clk        (clk),
        .wr_en_i    (wr_en),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (rd_data),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign data_mem_rd_o = data_req.read;
    assign data_mem_wr_o = data_req.write;
    assign data_addr_o   = data_req.addr;
    assign data_write_o  = data_req.wdata;

endmodule

//--- verification/core_tb.sv
`include "core_params.svh"

module core_tb import bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    logic        clk;
    logic        reset_i;
    logic        instr_flush_o;
    logic        instr_req_o;
    logic        instr_rsp_i;
    logic [31:0] instr_data_i;
    logic [31:0] instr_addr_o;
    logic        data_mem_rsp_i;
    logic        data_mem_rd_o;
    logic        data_mem_wr_o;
    logic [31:0] data_read_i;
    logic [31:0] data_addr_o;
    logic [31:0] data_write_o;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] vec_words [$];
    int          t_nprog [8];
    int          t_ndata [8];
    int          t_nstore [8];
    int          t_rand [8];
    int          t_ofs [8];
    int          ntests;
    int          errors;
    int          store_idx;
    int          cur_test;
    int          random_delay;
    bit          first_fetch_pending;
    longint      watchdog_ns;

    // Responder sampled state
    logic        i_req_s;
    logic        i_flush_s;
    logic        i_rsp_s;
    logic        i_rst_s;
    logic        i_busy;
    logic [31:0] i_addr_s;
    int          i_cnt;
    logic        d_rd_s;
    logic        d_wr_s;
    logic        d_rsp_s;
    logic        d_rst_s;
    logic        d_busy;
    data_req_t   d_req_s;
    int          d_cnt;

    core core_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_flush_o  (instr_flush_o),
        .instr_req_o    (instr_req_o),
        .instr_rsp_i    (instr_rsp_i),
        .instr_data_i   (instr_data_i),
        .instr_addr_o   (instr_addr_o),
        .data_mem_rsp_i (data_mem_rsp_i),
        .data_mem_rd_o  (data_mem_rd_o),
        .data_mem_wr_o  (data_mem_wr_o),
        .data_read_i    (data_read_i),
        .data_addr_o    (data_addr_o),
        .data_write_o   (data_write_o)
    );

    always #50 clk = ~clk;

    task automatic compare_store(input data_req_t got, input logic [31:0] exp_addr,
                                 input logic [31:0] exp_data);
        if (got.read || got.addr !== exp_addr || got.wdata !== exp_data) begin
            $display("MISMATCH at %0t: store addr %h data %h, expected addr %h data %h",
                     $time, got.addr, got.wdata, exp_addr, exp_data);
            errors++;
        end
    endtask

    task automatic compare_fetch(input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: first fetch address %h, expected %h",
                     $time, got, expected);
            errors++;
        end
    endtask

    // Request, flush, read and write strobes must all be low
    task automatic compare_idle(input logic [3:0] got);
        if (got !== 4'b0000) begin
            $display("MISMATCH at %0t: req/flush/rd/wr = %b around reset, expected 0000",
                     $time, got);
            errors++;
        end
    endtask

    task automatic record_store(input data_req_t got);
        int base;
        base = t_ofs[cur_test] + t_nprog[cur_test] + t_ndata[cur_test] + 2 * store_idx;
        if (store_idx >= t_nstore[cur_test]) begin
            $display("Test %0d wrote an extra store to %h after all expected stores were seen",
                     cur_test, got.addr);
            errors++;
        end else begin
            compare_store(got, vec_words[base], vec_words[base + 1]);
        end
        store_idx++;
    endtask

    // Instruction responder
    always @(posedge clk) begin
        i_req_s = instr_req_o;
        i_flush_s = instr_flush_o;
        i_rsp_s = instr_rsp_i;
        i_rst_s = reset_i;
        i_addr_s = instr_addr_o;
        if (!i_rst_s && i_req_s && first_fetch_pending) begin
            compare_fetch(i_addr_s, `BOOT_ADDRESS);
            first_fetch_pending = 1'b0;
        end
        #1;
        if (i_rst_s || i_flush_s || i_rsp_s) begin
            instr_rsp_i = 1'b0;
            i_busy = 1'b0;
        end else if (i_req_s) begin
            if (!i_busy) begin
                i_busy = 1'b1;
                i_cnt = random_delay ? $urandom_range(3, 0) : 0;
            end
            if (i_cnt == 0) begin
                instr_rsp_i = 1'b1;
                instr_data_i = imem[i_addr_s[9:2]];
            end else begin
                i_cnt--;
            end
        end
    end

    // Data responder
    always @(posedge clk) begin
        d_rd_s = data_mem_rd_o;
        d_wr_s = data_mem_wr_o;
        d_rsp_s = data_mem_rsp_i;
        d_rst_s = reset_i;
        d_req_s = '{read: d_rd_s, write: d_wr_s, addr: data_addr_o, wdata: data_write_o};
        if (!d_rst_s && d_rsp_s && d_wr_s) begin
            record_store(d_req_s);
        end
        #1;
        if (d_rst_s || d_rsp_s) begin
            data_mem_rsp_i = 1'b0;
            d_busy = 1'b0;
        end else if (d_rd_s || d_wr_s) begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_cnt = random_delay ? $urandom_range(3, 0) : 0;
            end
            if (d_cnt == 0) begin
                data_mem_rsp_i = 1'b1;
                if (d_wr_s) begin
                    dmem[d_req_s.addr[9:2]] = d_req_s.wdata;
                end else begin
                    data_read_i = dmem[d_req_s.addr[9:2]];
                end
            end else begin
                d_cnt--;
            end
        end
    end

    task automatic run_test(input int t);
        int err_before;
        err_before = errors;
        // LUI x0 fill carries its own byte address
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i << 14) | 32'h0000_0037;
            dmem[i] = 32'hd00d_0000 ^ (i << 2);
        end
        for (int i = 0; i < t_nprog[t]; i++) begin
            imem[i] = vec_words[t_ofs[t] + i];
        end
        // Spin on jal x0,0 right after the program
        imem[t_nprog[t]] = 32'h0000_006f;
        // Data words start at 0x100
        for (int i = 0; i < t_ndata[t]; i++) begin
            dmem[64 + i] = vec_words[t_ofs[t] + t_nprog[t] + i];
        end
        @(posedge clk);
        #1 reset_i = 1'b1;
        cur_test = t;
        store_idx = 0;
        random_delay = t_rand[t];
        @(posedge clk);
        @(posedge clk);
        compare_idle({instr_req_o, instr_flush_o, data_mem_rd_o, data_mem_wr_o});
        #1 reset_i = 1'b0;
        first_fetch_pending = 1'b1;
        @(posedge clk);
        compare_idle({instr_req_o, instr_flush_o, data_mem_rd_o, data_mem_wr_o});
        while (store_idx < t_nstore[t]) begin
            @(posedge clk);
        end
        // Catch stores from a path that should have been skipped
        repeat (20) @(posedge clk);
        if (first_fetch_pending) begin
            $display("Test %0d never issued an instruction fetch", t);
            errors++;
        end
        $display("Test %0d: %s, %0d stores seen", t,
                 (errors == err_before) ? "PASS" : "FAIL", store_idx);
    endtask

    initial begin
        watchdog_ns = 0;
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout: the tests did not finish in %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int fd;
        int code;
        int total_instr;
        int passed;
        int failed;
        int err_before;
        bit vectors_ok;
        string line;
        logic [31:0] word;
        clk = 1'b0;
        reset_i = 1'b1;
        instr_rsp_i = 1'b0;
        instr_data_i = '0;
        data_mem_rsp_i = 1'b0;
        data_read_i = '0;
        i_busy = 1'b0;
        d_busy = 1'b0;
        errors = 0;
        cur_test = 0;
        store_idx = 0;
        random_delay = 0;
        first_fetch_pending = 1'b0;
        passed = 0;
        failed = 0;
        total_instr = 0;
        vectors_ok = 1'b1;
        code = $urandom(59201);
        fd = $fopen("verification/core_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vectors file");
            $display("Simulation failed");
            $finish;
        end else begin
            code = $fgets(line, fd);
            code = $fgets(line, fd);
            code = $fscanf(fd, "%d", ntests);
            if (code != 1) begin
                vectors_ok = 1'b0;
            end
            for (int t = 0; t < ntests; t++) begin
                code = $fscanf(fd, "%d %d %d %d", t_nprog[t], t_ndata[t], t_nstore[t], t_rand[t]);
                if (code != 4) begin
                    vectors_ok = 1'b0;
                end
                t_ofs[t] = vec_words.size();
                total_instr += t_nprog[t];
                for (int i = 0; i < t_nprog[t] + t_ndata[t] + 2 * t_nstore[t]; i++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        vectors_ok = 1'b0;
                    end
                    vec_words.push_back(word);
                end
            end
            $fclose(fd);
            if (!vectors_ok) begin
                $display("The vectors file ended early or holds a malformed entry");
                errors++;
            end
            watchdog_ns = (longint'(total_instr) * 20 + ntests * 40) * 100;
            for (int t = 0; t < ntests; t++) begin
                err_before = errors;
                run_test(t);
                if (errors == err_before) begin
                    passed++;
                end else begin
                    failed++;
                end
            end
            $display("Tests passed: %0d, failed: %0d", passed, failed);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+src
src/isa_pkg.sv
src/bus_pkg.sv
src/fetch_unit.sv
src/fetch_queue.sv
src/register_bank.sv
src/execute_unit.sv
src/core.sv
verification/core_tb.sv

//--- verification/core_vectors.txt
# Third line holds the test count. Each test: nprog ndata nstore random_delay, then hex
# program words, data words from address 0x100, and expected store address/data pairs
4
16 0 6 0
123450b7 ffb00113 67808193 00218233 403102b3 0021f333 0020e3b3 0011c433
003124b3 10000513 00452023 00552223 00652423 00752623 00852823 00952a23
00000100 12345673 00000104 edcba983 00000108 12345678
0000010c fffffffb 00000110 00000678 00000114 00000001
10 3 3 0
10000513 00052083 00452103 00852183 00208233 06418293 00452423 00552023
00852303 00652623
00000010 7ffffff0 00000003
00000108 80000000 00000100 00000067 0000010c 80000000
17 0 4 0
10000513 00500093 00500113 00208663 00152023 00152023 00252223 00209463
00700193 00c002ef 00152023 00152023 00352423 00552623 00119463 00152023
00152823
00000104 00000005 00000108 00000007 0000010c 00000028 00000110 00000005
17 0 4 1
10000513 00500093 00500113 00208663 00152023 00152023 00252223 00209463
00700193 00c002ef 00152023 00152023 00352423 00552623 00119463 00152023
00152823
00000104 00000005 00000108 00000007 0000010c 00000028 00000110 00000005
